// ==== verif/ifetch_testdata.txt ====
# start_addr(hex) count integrity dbg mode
# mode 0 none, 1 bad rchk, 2 bad gntpar, 3 bad rvalidpar, 4 spurious rvalid
00000000 4 1 0 0
00001000 6 0 1 0
00002010 12 1 0 0
00000100 3 1 0 1
00000200 3 0 0 1
00003000 5 0 1 2
00000400 5 1 0 3
00000500 2 0 0 4
80001ffc 9 1 1 0
00000600 0 1 0 0
0000f000 16 0 0 2
12345678 7 1 0 1

// ==== sim.f ====
+incdir+include
verilog/ifetch_pkg.sv
verilog/fetch_req_gen.sv
verilog/obi_instr_adapter.sv
verilog/obi_resp_tracker.sv
verilog/instr_resp_buffer.sv
verilog/ifetch_top.sv
verif/obi_mem_model.sv
verif/ifetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module ifetch_tb -o ifetch_sim \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/ifetch_sim > sim.log 2>&1
grep -q "Test FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Test OK" sim.log && echo "Simulation passed" && exit 0 ||
  { echo "Simulation ended without a result, see sim.log"; exit 1; }

// ==== verif/ifetch_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the fetch subsystem, replays commands from the testdata file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ifetch_consts.svh"

module ifetch_tb;

  localparam int         TIMEOUT    = 4000;
  localparam logic [2:0] BAD_RCHK   = 3'd1;
  localparam logic [2:0] BAD_GNTPAR = 3'd2;
  localparam logic [2:0] BAD_RVPAR  = 3'd3;
  localparam logic [2:0] SPURIOUS   = 3'd4;

  logic clk;
  logic rst_n;
  logic cmd_valid;
  logic cmd_ready;
  ifetch_pkg::fetch_cmd_t  cmd;
  logic obi_req;
  logic obi_reqpar;
  logic obi_gnt;
  logic obi_gntpar;
  logic obi_rvalid;
  logic obi_rvalidpar;
  ifetch_pkg::obi_req_t    obi_a;
  ifetch_pkg::obi_resp_t   obi_r;
  logic out_valid;
  ifetch_pkg::instr_resp_t out;
  logic credit;
  logic integrity_err;
  logic protocol_err;

  logic [31:0] lfsr_q = 32'hcae0_8293;
  logic [3:0]  rnd;
  logic [1:0]  cbits;
  logic [2:0]  cur_mode;
  logic [31:0] cur_tgt;
  logic        cur_integ;
  logic        spurious;
  logic        model_viol;
  int          held_cred;
  int          ret_pend;
  ifetch_pkg::instr_resp_t exp_q [$];
  logic [31:0] bus_q [$];

  ifetch_top u_dut (
    .clk (clk), .rst_n (rst_n),
    .cmd_valid_i (cmd_valid), .cmd_ready_o (cmd_ready), .cmd_i (cmd),
    .obi_req_o (obi_req), .obi_reqpar_o (obi_reqpar), .obi_a_o (obi_a),
    .obi_gnt_i (obi_gnt), .obi_gntpar_i (obi_gntpar),
    .obi_rvalid_i (obi_rvalid), .obi_rvalidpar_i (obi_rvalidpar), .obi_r_i (obi_r),
    .out_valid_o (out_valid), .out_o (out), .credit_i (credit),
    .integrity_err_o (integrity_err), .protocol_err_o (protocol_err)
  );

  obi_mem_model u_mem (
    .clk (clk), .rst_n (rst_n), .req_i (obi_req), .reqpar_i (obi_reqpar), .a_i (obi_a),
    .gnt_o (obi_gnt), .gntpar_o (obi_gntpar), .rvalid_o (obi_rvalid),
    .rvalidpar_o (obi_rvalidpar), .r_o (obi_r), .rnd_i (rnd), .mode_i (cur_mode),
    .tgt_addr_i (cur_tgt), .spurious_i (spurious), .viol_o (model_viol)
  );

  always #20 clk = ~clk;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[6:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_resp(input ifetch_pkg::instr_resp_t got,
                            input ifetch_pkg::instr_resp_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t: word addr %h got %h/%b/%b exp %h/%b/%b",
                          $time, exp.addr, got.rdata, got.bus_err, got.integrity_err,
                          exp.rdata, exp.bus_err, exp.integrity_err));
    end
  endtask

  task automatic check_alert(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  // Injected errors hit only the first word of a command
  function automatic logic word_int_err(input logic [31:0] addr);
    if (addr != cur_tgt) return 1'b0;
    return (cur_mode == BAD_GNTPAR) || (cur_mode == BAD_RVPAR) ||
           ((cur_mode == BAD_RCHK) && cur_integ);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Consumer credits and per cycle monitor, sampled 5 ns before the edge
  ////////////////////////////////////////////////////////////////////////////

  always begin
    logic [7:0] v;
    logic       exp_alert;
    @(negedge clk);
    // Flag raised by the model in the previous cycle
    if (rst_n && model_viol) abort_run("Bus model saw an illegal address phase");
    credit = (ret_pend > 0) && (cbits == 2'b00);
    if (credit) ret_pend--;
    #15;
    if (rst_n) begin
      if (out_valid) begin
        if (held_cred == 0) abort_run($sformatf("ERROR at %0t: word sent without credit", $time));
        if (exp_q.size() == 0) abort_run($sformatf("ERROR at %0t: unexpected word", $time));
        check_resp(out, exp_q.pop_front());
      end
      exp_alert = (obi_gnt == obi_gntpar) || (obi_rvalid == obi_rvalidpar) ||
                  (obi_rvalid && (bus_q.size() > 0) && word_int_err(bus_q[0]));
      check_alert(integrity_err, exp_alert, "integrity_err_o");
      check_alert(protocol_err, obi_rvalid && (bus_q.size() == 0), "protocol_err_o");
      if (obi_rvalid && (bus_q.size() > 0)) void'(bus_q.pop_front());
      if (obi_req && obi_gnt) bus_q.push_back(obi_a.addr);
      if (bus_q.size() > `IFETCH_BUF_DEPTH) abort_run("Too many outstanding bus requests");
      held_cred = held_cred - int'(out_valid) + int'(credit);
      if (out_valid) ret_pend++;
    end
    take_bits(4, v);
    rnd = v[3:0];
    take_bits(2, v);
    cbits = v[1:0];
  end

  task automatic send_cmd(input logic [31:0] addr, input int cnt, input logic integ,
                          input logic dbg);
    logic                    seen;
    int                      t;
    logic [31:0]             waddr;
    ifetch_pkg::instr_resp_t e;
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd       = '{addr: addr, count: 8'(cnt), integrity: integ, dbg: dbg};
    seen      = 1'b0;
    t         = 0;
    while (!seen) begin
      #15;
      seen = cmd_ready;
      if (seen) begin
        for (int i = 0; i < cnt; i++) begin
          waddr           = addr + 32'(4 * i);
          e.addr          = waddr;
          e.rdata         = waddr ^ 32'h5a5a_0000;
          e.bus_err       = addr_bit12(waddr);
          e.integrity_err = word_int_err(waddr);
          exp_q.push_back(e);
        end
      end
      if (++t > TIMEOUT) abort_run("Timeout waiting for cmd_ready_o");
      @(negedge clk);
    end
    cmd_valid = 1'b0;
  endtask

  function automatic logic addr_bit12(input logic [31:0] a);
    return a[12];
  endfunction

  task automatic wait_drain();
    int t;
    t = 0;
    do begin
      @(posedge clk);
      if (++t > TIMEOUT) abort_run("Timeout waiting for all words to arrive");
    end while ((exp_q.size() != 0) || (bus_q.size() != 0));
  endtask

  task automatic pulse_spurious();
    @(negedge clk);
    #15;
    spurious = 1'b1;
    @(negedge clk);
    #15;
    spurious = 1'b0;
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] addr;
    int          cnt;
    int          integ;
    int          dbg;
    int          mode;
    clk       = 1'b0;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    credit    = 1'b0;
    rnd       = '0;
    cbits     = '0;
    cur_mode  = '0;
    cur_tgt   = '1;
    cur_integ = 1'b0;
    spurious  = 1'b0;
    held_cred = `IFETCH_OUT_CREDITS;
    ret_pend  = 0;
    // Reset spans three rising edges
    @(negedge clk);
    repeat (2) begin
      #15;
      check_alert(cmd_ready, 1'b0, "cmd_ready_o in reset");
      check_alert(obi_req, 1'b0, "obi_req_o in reset");
      check_alert(out_valid, 1'b0, "out_valid_o in reset");
      check_alert(integrity_err, 1'b0, "integrity_err_o in reset");
      check_alert(protocol_err, 1'b0, "protocol_err_o in reset");
      @(negedge clk);
    end
    rst_n = 1'b1;
    fd = $fopen("verif/ifetch_testdata.txt", "r");
    if (fd == 0) abort_run("Could not open the testdata file");
    while ($fgets(line, fd) != 0) begin
      if ((line.len() < 2) || (line.getc(0) == 8'h23)) continue;
      n = $sscanf(line, "%h %d %d %d %d", addr, cnt, integ, dbg, mode);
      if (n != 5) abort_run("Malformed line in the testdata file");
      @(posedge clk);
      cur_mode  = 3'(mode);
      cur_tgt   = addr;
      cur_integ = integ[0];
      send_cmd(addr, cnt, integ[0], dbg[0]);
      wait_drain();
      if (cur_mode == SPURIOUS) pulse_spurious();
    end
    $fclose(fd);
    repeat (4) @(posedge clk);
    $display("Test OK");
    $finish;
  end

endmodule

// ==== verif/obi_mem_model.sv ====
////////////////////////////////////////////////////////////////////////////
// OBI instruction slave for the testbench with random delays and injection
// Checks address phase stability, request parity and the address checksum
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module obi_mem_model (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  logic                  reqpar_i,
  input  ifetch_pkg::obi_req_t  a_i,
  output logic                  gnt_o,
  output logic                  gntpar_o,
  output logic                  rvalid_o,
  output logic                  rvalidpar_o,
  output ifetch_pkg::obi_resp_t r_o,
  input  logic [3:0]            rnd_i,
  input  logic [2:0]            mode_i,
  input  logic [31:0]           tgt_addr_i,
  input  logic                  spurious_i,
  output logic                  viol_o
);

  // Injection modes
  localparam logic [2:0] BAD_RCHK   = 3'd1;
  localparam logic [2:0] BAD_GNTPAR = 3'd2;
  localparam logic [2:0] BAD_RVPAR  = 3'd3;

  logic [31:0]          resp_q [$];
  int                   gwait;
  int                   rwait;
  logic                 held;
  ifetch_pkg::obi_req_t held_a;
  logic [3:0]           rnd;
  logic [31:0]          raddr;

  // Even parity per address byte with the top byte in bit 5
  // Odd parity of prot in bit 1 and of dbg in bit 0
  function automatic logic [5:0] addr_chk(input ifetch_pkg::obi_req_t a);
    logic [5:0] c;
    c[5] = ($countones(a.addr[31:24]) % 2) == 1;
    c[4] = ($countones(a.addr[23:16]) % 2) == 1;
    c[3] = ($countones(a.addr[15:8]) % 2) == 1;
    c[2] = ($countones(a.addr[7:2]) % 2) == 1;
    c[1] = ($countones(a.prot) % 2) == 0;
    c[0] = !a.dbg;
    return c;
  endfunction

  // Memory rule with an optional corrupted checksum
  function automatic ifetch_pkg::obi_resp_t mem_word(input logic [31:0] addr,
                                                     input logic bad);
    ifetch_pkg::obi_resp_t r;
    r.rdata = addr ^ 32'h5a5a_0000;
    r.err   = addr[12];
    // Byte b of rdata gives bit b, err on top
    for (int b = 0; b < 4; b++) begin
      r.rchk[b] = ($countones(r.rdata[8*b +: 8]) % 2) == 1;
    end
    r.rchk[4] = r.err;
    if (bad) r.rchk[0] = ~r.rchk[0];
    return r;
  endfunction

  task automatic report(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    viol_o = 1'b1;
  endtask

  initial begin
    gnt_o       = 1'b0;
    gntpar_o    = 1'b1;
    rvalid_o    = 1'b0;
    rvalidpar_o = 1'b1;
    r_o         = '0;
    viol_o      = 1'b0;
    gwait       = 0;
    rwait       = 0;
    held        = 1'b0;
    held_a      = '0;
  end

  always begin
    @(negedge clk);
    rnd         = rnd_i;
    gnt_o       = 1'b0;
    gntpar_o    = 1'b1;
    rvalid_o    = 1'b0;
    rvalidpar_o = 1'b1;
    r_o         = '0;
    if (!rst_n) begin
      resp_q.delete();
      held = 1'b0;
    end else begin
      // Grant after the chosen number of wait cycles
      if (req_i) begin
        if (gwait == 0) begin
          gnt_o    = 1'b1;
          gntpar_o = (mode_i == BAD_GNTPAR) && (a_i.addr == tgt_addr_i);
        end else begin
          gwait--;
        end
      end
      // Responses in grant order
      if (resp_q.size() != 0) begin
        if (rwait == 0) begin
          raddr       = resp_q.pop_front();
          rvalid_o    = 1'b1;
          rvalidpar_o = (mode_i == BAD_RVPAR) && (raddr == tgt_addr_i);
          r_o         = mem_word(raddr, (mode_i == BAD_RCHK) && (raddr == tgt_addr_i));
          rwait       = int'(rnd[3:2]);
        end else begin
          rwait--;
        end
      end else if (spurious_i) begin
        rvalid_o    = 1'b1;
        rvalidpar_o = 1'b0;
        r_o         = mem_word(32'h0, 1'b0);
      end
      #15;
      if (reqpar_i == req_i) report("request parity line equals req");
      if (req_i && (a_i.achk != addr_chk(a_i))) report("address checksum mismatch");
      if (held && (!req_i || (a_i != held_a))) report("address phase changed before grant");
      if (req_i && gnt_o) begin
        resp_q.push_back(a_i.addr);
        gwait = int'(rnd[1:0]);
        held  = 1'b0;
      end else begin
        held   = req_i;
        held_a = a_i;
      end
    end
  end

endmodule

// ==== verilog/ifetch_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Instruction fetch subsystem top, generator to OBI bus to response buffer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ifetch_consts.svh"

module ifetch_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  input  ifetch_pkg::fetch_cmd_t  cmd_i,
  output logic                    obi_req_o,
  output logic                    obi_reqpar_o,
  output ifetch_pkg::obi_req_t    obi_a_o,
  input  logic                    obi_gnt_i,
  input  logic                    obi_gntpar_i,
  input  logic                    obi_rvalid_i,
  input  logic                    obi_rvalidpar_i,
  input  ifetch_pkg::obi_resp_t   obi_r_i,
  output logic                    out_valid_o,
  output ifetch_pkg::instr_resp_t out_o,
  input  logic                    credit_i,
  output logic                    integrity_err_o,
  output logic                    protocol_err_o
);

  logic                    trans_valid;
  logic                    trans_ready;
  ifetch_pkg::obi_req_t    trans;
  logic                    buf_credit;
  logic                    gntpar_err;
  logic                    rvalidpar_err;
  logic                    resp_integrity_err;
  ifetch_pkg::instr_resp_t wr_data;

  // Address field is filled in by the buffer
  assign wr_data = '{addr: '0, rdata: obi_r_i.rdata, bus_err: obi_r_i.err,
                     integrity_err: resp_integrity_err};

  // Alert on any parity error or checksum error
  assign integrity_err_o = gntpar_err || rvalidpar_err || resp_integrity_err;

  fetch_req_gen u_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_i         (cmd_i),
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_o       (trans),
    .buf_credit_i  (buf_credit)
  );

  obi_instr_adapter u_adapter (
    .clk             (clk),
    .rst_n           (rst_n),
    .trans_valid_i   (trans_valid),
    .trans_ready_o   (trans_ready),
    .trans_i         (trans),
    .obi_req_o       (obi_req_o),
    .obi_reqpar_o    (obi_reqpar_o),
    .obi_a_o         (obi_a_o),
    .obi_gnt_i       (obi_gnt_i),
    .obi_gntpar_i    (obi_gntpar_i),
    .obi_rvalid_i    (obi_rvalid_i),
    .obi_rvalidpar_i (obi_rvalidpar_i),
    .gntpar_err_o    (gntpar_err),
    .rvalidpar_err_o (rvalidpar_err)
  );

  obi_resp_tracker #(
    .MAX_OUTSTANDING (`IFETCH_BUF_DEPTH)
  ) u_tracker (
    .clk                  (clk),
    .rst_n                (rst_n),
    .obi_req_i            (obi_req_o),
    .obi_gnt_i            (obi_gnt_i),
    .obi_rvalid_i         (obi_rvalid_i),
    .obi_r_i              (obi_r_i),
    .integrity_i          (obi_a_o.integrity),
    .gntpar_err_i         (gntpar_err),
    .rvalidpar_err_i      (rvalidpar_err),
    .resp_integrity_err_o (resp_integrity_err),
    .protocol_err_o       (protocol_err_o)
  );

  instr_resp_buffer u_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .addr_push_i  (obi_req_o && obi_gnt_i),
    .addr_i       (obi_a_o.addr),
    .wr_i         (obi_rvalid_i),
    .wr_data_i    (wr_data),
    .buf_credit_o (buf_credit),
    .credit_i     (credit_i),
    .out_valid_o  (out_valid_o),
    .out_o        (out_o)
  );

endmodule

// ==== verilog/instr_resp_buffer.sv ====
////////////////////////////////////////////////////////////////////////////
// Response buffer that tags words with their address and delivers them
// under consumer credits, returning one internal credit per word sent
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ifetch_consts.svh"

module instr_resp_buffer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    addr_push_i,
  input  logic [31:0]             addr_i,
  input  logic                    wr_i,
  input  ifetch_pkg::instr_resp_t wr_data_i,
  output logic                    buf_credit_o,
  input  logic                    credit_i,
  output logic                    out_valid_o,
  output ifetch_pkg::instr_resp_t out_o
);

  localparam int DEPTH = `IFETCH_BUF_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(`IFETCH_OUT_CREDITS + DEPTH + 1);

  logic [31:0]             addr_q [DEPTH];
  ifetch_pkg::instr_resp_t data_q [DEPTH];
  logic [PTR_W-1:0]        a_wptr_q;
  logic [PTR_W-1:0]        a_rptr_q;
  logic [CNT_W-1:0]        a_cnt_q;
  logic [PTR_W-1:0]        d_wptr_q;
  logic [PTR_W-1:0]        d_rptr_q;
  logic [CNT_W-1:0]        d_cnt_q;
  logic [CRD_W-1:0]        out_cred_q;
  logic                    wr_ok;
  logic                    send;

  // Response with no address recorded is dropped
  assign wr_ok        = wr_i && (a_cnt_q != '0);
  assign out_valid_o  = (d_cnt_q != '0) && (out_cred_q != '0);
  assign send         = out_valid_o;
  assign buf_credit_o = send;
  assign out_o        = data_q[d_rptr_q];

  ////////////////////////////////////////////////////////////////////////////
  // Address FIFO, filled at grant
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_wptr_q <= '0;
      a_rptr_q <= '0;
      a_cnt_q  <= '0;
    end else begin
      if (addr_push_i) a_wptr_q <= a_wptr_q + 1'b1;
      if (wr_ok) a_rptr_q <= a_rptr_q + 1'b1;
      a_cnt_q <= a_cnt_q + CNT_W'(addr_push_i) - CNT_W'(wr_ok);
    end
  end

  always_ff @(posedge clk) begin
    if (addr_push_i) addr_q[a_wptr_q] <= addr_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data FIFO and consumer credits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_wptr_q   <= '0;
      d_rptr_q   <= '0;
      d_cnt_q    <= '0;
      out_cred_q <= CRD_W'(`IFETCH_OUT_CREDITS);
    end else begin
      if (wr_ok) d_wptr_q <= d_wptr_q + 1'b1;
      if (send) d_rptr_q <= d_rptr_q + 1'b1;
      d_cnt_q    <= d_cnt_q + CNT_W'(wr_ok) - CNT_W'(send);
      // Consumer hands one credit back per finished word
      out_cred_q <= out_cred_q + CRD_W'(credit_i) - CRD_W'(send);
    end
  end

  // Word tagged with the address granted in the same order
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      data_q[d_wptr_q]      <= wr_data_i;
      data_q[d_wptr_q].addr <= addr_q[a_rptr_q];
    end
  end

  // Internal credits keep a free slot for every response
  a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
    wr_ok |-> (d_cnt_q != CNT_W'(DEPTH)));

endmodule

// ==== verilog/obi_resp_tracker.sv ====
////////////////////////////////////////////////////////////////////////////
// Per transaction record of integrity attribute and grant parity error
// Checks the response checksum and flags rvalid with nothing outstanding
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ifetch_consts.svh"

module obi_resp_tracker #(
  parameter int MAX_OUTSTANDING = `IFETCH_BUF_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  obi_req_i,
  input  logic                  obi_gnt_i,
  input  logic                  obi_rvalid_i,
  input  ifetch_pkg::obi_resp_t obi_r_i,
  input  logic                  integrity_i,
  input  logic                  gntpar_err_i,
  input  logic                  rvalidpar_err_i,
  output logic                  resp_integrity_err_o,
  output logic                  protocol_err_o
);

  localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  // Entry bit 1 integrity attribute, bit 0 grant parity error
  logic [1:0]                fifo_q [MAX_OUTSTANDING];
  logic [PTR_W-1:0]          wptr_q;
  logic [PTR_W-1:0]          rptr_q;
  logic [CNT_W-1:0]          cnt_q;
  logic                      empty;
  logic                      full;
  logic                      push;
  logic                      pop;
  logic [1:0]                head;
  logic [`IFETCH_RCHK_W-1:0] rchk_calc;
  logic                      rchk_err;

  assign empty = (cnt_q == '0);
  assign full  = (cnt_q == CNT_W'(MAX_OUTSTANDING));
  assign push  = obi_req_i && obi_gnt_i;
  assign pop   = obi_rvalid_i && !empty;
  assign head  = fifo_q[rptr_q];

  // Expected checksum, byte 3 parity in bit 3, err parity in bit 4
  assign rchk_calc = {
    obi_r_i.err,
    ^obi_r_i.rdata[31:24],
    ^obi_r_i.rdata[23:16],
    ^obi_r_i.rdata[15:8],
    ^obi_r_i.rdata[7:0]
  };

  // Mismatch matters only with the integrity attribute set
  assign rchk_err = head[1] && (rchk_calc != obi_r_i.rchk);

  assign resp_integrity_err_o = obi_rvalid_i &&
                                (rvalidpar_err_i || (!empty && (rchk_err || head[0])));
  assign protocol_err_o       = obi_rvalid_i && empty;

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_q[wptr_q] <= {integrity_i, gntpar_err_i};
    end
  end

  // Credits keep the grant count within the record depth
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full);

endmodule

// ==== verilog/obi_instr_adapter.sv ====
////////////////////////////////////////////////////////////////////////////
// OBI instruction address phase adapter with checksum and parity checks
// Keeps the request stable from req until gnt
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module obi_instr_adapter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 trans_valid_i,
  output logic                 trans_ready_o,
  input  ifetch_pkg::obi_req_t trans_i,
  output logic                 obi_req_o,
  output logic                 obi_reqpar_o,
  output ifetch_pkg::obi_req_t obi_a_o,
  input  logic                 obi_gnt_i,
  input  logic                 obi_gntpar_i,
  input  logic                 obi_rvalid_i,
  input  logic                 obi_rvalidpar_i,
  output logic                 gntpar_err_o,
  output logic                 rvalidpar_err_o
);

  ifetch_pkg::obi_if_state_e state_q;
  ifetch_pkg::obi_if_state_e state_d;
  ifetch_pkg::obi_req_t      req_with_chk;
  ifetch_pkg::obi_req_t      a_q;

  ////////////////////////////////////////////////////////////////////////////
  // Address phase checksum
  ////////////////////////////////////////////////////////////////////////////

  // Bits 5..2 even parity of address bytes, top byte in bit 5
  // Bit 1 odd parity of prot, bit 0 odd parity of dbg
  always_comb begin
    req_with_chk      = trans_i;
    req_with_chk.achk = {
      ^trans_i.addr[31:24],
      ^trans_i.addr[23:16],
      ^trans_i.addr[15:8],
      ^trans_i.addr[7:2],
      ~^trans_i.prot,
      ~^trans_i.dbg
    };
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address phase FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Request waits for gnt, so hold it from registers
      ifetch_pkg::TRANSPARENT: if (obi_req_o && !obi_gnt_i) state_d = ifetch_pkg::REGISTERED;
      ifetch_pkg::REGISTERED:  if (obi_gnt_i) state_d = ifetch_pkg::TRANSPARENT;
      default:                 state_d = ifetch_pkg::TRANSPARENT;
    endcase
  end

  // Pass through when transparent, replay the held copy otherwise
  always_comb begin
    if (state_q == ifetch_pkg::TRANSPARENT) begin
      obi_req_o = trans_valid_i;
      obi_a_o   = req_with_chk;
    end else begin
      obi_req_o = 1'b1;
      obi_a_o   = a_q;
    end
  end

  assign obi_reqpar_o  = ~obi_req_o;
  // A request is taken in the transparent state, granted or not
  assign trans_ready_o = (state_q == ifetch_pkg::TRANSPARENT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ifetch_pkg::TRANSPARENT;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture on entry to the registered state
  always_ff @(posedge clk) begin
    if ((state_q == ifetch_pkg::TRANSPARENT) && (state_d == ifetch_pkg::REGISTERED)) begin
      a_q <= req_with_chk;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Parity checks
  ////////////////////////////////////////////////////////////////////////////

  // Parity line must be the inverse, checked every cycle
  assign gntpar_err_o    = (obi_gnt_i == obi_gntpar_i);
  assign rvalidpar_err_o = (obi_rvalid_i == obi_rvalidpar_i);

  // Ungranted request stays up with an unchanged payload
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (obi_req_o && !obi_gnt_i) |=> (obi_req_o && $stable(obi_a_o)));

endmodule

// ==== verilog/fetch_req_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Takes fetch commands and issues sequential word requests to the adapter
// Issue is limited by credits for free response buffer slots
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ifetch_consts.svh"

module fetch_req_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  ifetch_pkg::fetch_cmd_t cmd_i,
  output logic                   trans_valid_o,
  input  logic                   trans_ready_i,
  output ifetch_pkg::obi_req_t   trans_o,
  input  logic                   buf_credit_i
);

  localparam int CRED_W = $clog2(`IFETCH_BUF_DEPTH + 1);
  // Machine mode instruction access
  localparam logic [2:0] PROT_M_INSTR = 3'b110;

  ifetch_pkg::fetch_state_e state_q;
  logic                     live_q;
  logic [31:0]              addr_q;
  logic [7:0]               remain_q;
  logic                     integrity_q;
  logic                     dbg_q;
  logic [CRED_W-1:0]        credits_q;
  logic                     cmd_take;
  logic                     issue;

  // Ready only once out of reset and idle
  assign cmd_ready_o   = live_q && (state_q == ifetch_pkg::IDLE);
  assign cmd_take      = cmd_valid_i && cmd_ready_o;
  assign trans_valid_o = (state_q == ifetch_pkg::ISSUE) && (credits_q != '0);
  assign issue         = trans_valid_o && trans_ready_i;

  // Request payload, checksum is filled in by the adapter
  always_comb begin
    trans_o           = '0;
    trans_o.addr      = addr_q;
    trans_o.prot      = PROT_M_INSTR;
    trans_o.dbg       = dbg_q;
    trans_o.integrity = integrity_q;
  end

  // FSM and word counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= ifetch_pkg::IDLE;
      live_q   <= 1'b0;
      remain_q <= '0;
    end else begin
      live_q <= 1'b1;
      case (state_q)
        ifetch_pkg::IDLE: begin
          // Zero length command is accepted and dropped
          if (cmd_take && (cmd_i.count != '0)) begin
            state_q  <= ifetch_pkg::ISSUE;
            remain_q <= cmd_i.count;
          end
        end
        ifetch_pkg::ISSUE: begin
          if (issue) begin
            remain_q <= remain_q - 8'd1;
            if (remain_q == 8'd1) begin
              state_q <= ifetch_pkg::IDLE;
            end
          end
        end
        default: state_q <= ifetch_pkg::IDLE;
      endcase
    end
  end

  // Next word address and command attributes
  always_ff @(posedge clk) begin
    if (cmd_take) begin
      addr_q      <= cmd_i.addr;
      integrity_q <= cmd_i.integrity;
      dbg_q       <= cmd_i.dbg;
    end else if (issue) begin
      addr_q <= addr_q + 32'd4;
    end
  end

  // One credit per free buffer slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits_q <= CRED_W'(`IFETCH_BUF_DEPTH);
    end else begin
      case ({issue, buf_credit_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  // Buffer never returns more credits than were spent
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credits_q <= CRED_W'(`IFETCH_BUF_DEPTH));

endmodule

// ==== verilog/ifetch_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types for the fetch subsystem RTL and testbench
////////////////////////////////////////////////////////////////////////////

`include "ifetch_consts.svh"

package ifetch_pkg;

  // Fetch command from the core side
  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  count;
    logic        integrity;
    logic        dbg;
  } fetch_cmd_t;

  // OBI address phase payload
  typedef struct packed {
    logic [31:0]               addr;
    logic [2:0]                prot;
    logic                      dbg;
    logic                      integrity;
    logic [`IFETCH_ACHK_W-1:0] achk;
  } obi_req_t;

  // OBI response phase payload
  typedef struct packed {
    logic [31:0]               rdata;
    logic                      err;
    logic [`IFETCH_RCHK_W-1:0] rchk;
  } obi_resp_t;

  // Word handed to the consumer
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        bus_err;
    logic        integrity_err;
  } instr_resp_t;

  // Adapter address phase FSM
  typedef enum logic {
    TRANSPARENT,
    REGISTERED
  } obi_if_state_e;

  // Request generator FSM
  typedef enum logic {
    IDLE,
    ISSUE
  } fetch_state_e;

endpackage

// ==== include/ifetch_consts.svh ====
////////////////////////////////////////////////////////////////////////////
// Sizing constants for the instruction fetch subsystem
// Included by the package, the RTL and the testbench
////////////////////////////////////////////////////////////////////////////

`ifndef IFETCH_CONSTS_SVH
`define IFETCH_CONSTS_SVH

// Response buffer slots, which is also the internal credit pool
// and the bound on outstanding bus transactions
`define IFETCH_BUF_DEPTH 4

// Credits the consumer grants at reset
`define IFETCH_OUT_CREDITS 2

// Address phase and response phase checksum widths
`define IFETCH_ACHK_W 6
`define IFETCH_RCHK_W 5

`endif
